/* Bender.yml */
package:
  name: inv_sqrt_unit

sources:
  - files:
      - hw/fp_pkg.sv
      - hw/fp_mul.sv
      - hw/fp_add.sv
      - hw/fp_inv_sqrt.sv
      - hw/int_to_fp.sv
      - hw/fp_to_fixed.sv
      - hw/inv_sqrt_unit.sv
  - target: test
    include_dirs:
      - dv
    files:
      - dv/inv_sqrt_unit_tb.sv

/* dv/fp_model.svh */
`ifndef FP_MODEL_SVH
`define FP_MODEL_SVH

// Unsigned integer to float, leading one becomes the hidden bit
function automatic fp_t int_to_float(input int_t v);
	int pos;
	logic [FRAC_WIDTH+INT_WIDTH-1:0] below;
	if (v == '0) begin
		return '0;
	end
	pos = 0;
	for (int i = 0; i < INT_WIDTH; i++) begin
		if (v[i]) begin
			pos = i;
		end
	end
	// Bits under the leading one, moved to the top of the fraction
	below = v & ((1 << pos) - 1);
	below = below << (FRAC_WIDTH - pos);
	return {1'b0, EXP_WIDTH'(EXP_BIAS + pos), below[FRAC_WIDTH-1:0]};
endfunction

// Product of two 18-bit significands, fraction LSB of each dropped
function automatic fp_t mul_float(input fp_t a, input fp_t b);
	logic [2*FRAC_WIDTH-1:0] p;
	logic [EXP_WIDTH:0] es;
	logic [EXP_WIDTH:0] e;
	logic [FRAC_WIDTH-1:0] frac;
	p = {1'b1, a[FRAC_WIDTH-1:1]} * {1'b1, b[FRAC_WIDTH-1:1]};
	es = a[FP_WIDTH-2 -: EXP_WIDTH] + b[FP_WIDTH-2 -: EXP_WIDTH];
	if ((a[FP_WIDTH-2 -: EXP_WIDTH] == '0) || (b[FP_WIDTH-2 -: EXP_WIDTH] == '0) || (es < 128)) begin
		return '0;
	end
	// Product at or above 2 carries one more power of two
	if (p[2*FRAC_WIDTH-1]) begin
		e = es - 126;
		frac = p[2*FRAC_WIDTH-2 -: FRAC_WIDTH];
	end else begin
		e = es - 127;
		frac = p[2*FRAC_WIDTH-3 -: FRAC_WIDTH];
	end
	return {a[FP_WIDTH-1] ^ b[FP_WIDTH-1], e[EXP_WIDTH-1:0], frac};
endfunction

// Aligned add in a 37-bit field, then normalize on the leading one
function automatic fp_t add_float(input fp_t a, input fp_t b);
	logic [EXP_WIDTH-1:0] ea;
	logic [EXP_WIDTH-1:0] eb;
	logic [EXP_WIDTH-1:0] e_big;
	logic [FRAC_WIDTH-1:0] sa;
	logic [FRAC_WIDTH-1:0] sb;
	logic [2*FRAC_WIDTH:0] wa;
	logic [2*FRAC_WIDTH:0] wb;
	logic [2*FRAC_WIDTH:0] raw;
	logic [3*FRAC_WIDTH-1:0] norm;
	logic [EXP_WIDTH:0] e_up;
	logic a_big;
	logic sign;
	int lz;
	ea = a[FP_WIDTH-2 -: EXP_WIDTH];
	eb = b[FP_WIDTH-2 -: EXP_WIDTH];
	sa = {1'b1, a[FRAC_WIDTH-1:1]};
	sb = {1'b1, b[FRAC_WIDTH-1:1]};
	wa = sa;
	wa = wa << FRAC_WIDTH;
	wb = sb;
	wb = wb << FRAC_WIDTH;
	// Ties on magnitude go to b
	a_big = (ea > eb) || ((ea == eb) && (sa > sb));
	// Shift of more than 35 places leaves nothing
	if (a_big) begin
		e_big = ea;
		sign = a[FP_WIDTH-1];
		wb = (ea - eb > 35) ? '0 : (wb >> (ea - eb));
	end else begin
		e_big = eb;
		sign = b[FP_WIDTH-1];
		wa = (eb - ea > 35) ? '0 : (wa >> (eb - ea));
	end
	if (a[FP_WIDTH-1] ^ b[FP_WIDTH-1]) begin
		raw = a_big ? (wa - wb) : (wb - wa);
	end else begin
		raw = wa + wb;
	end
	lz = 2 * FRAC_WIDTH + 1;
	for (int i = 0; i <= 2 * FRAC_WIDTH; i++) begin
		if (raw[i]) begin
			lz = 2 * FRAC_WIDTH - i;
		end
	end
	norm = {raw, {(FRAC_WIDTH-1){1'b0}}};
	norm = norm << (lz + 1);
	// Top bit of the field sits one above the larger exponent
	e_up = e_big + 1;
	if ((ea == '0) && (eb == '0)) begin
		return '0;
	end else if (ea == '0) begin
		return b;
	end else if (eb == '0) begin
		return a;
	end else if ((e_up <= lz) || (raw == '0)) begin
		return '0;
	end
	return {sign, EXP_WIDTH'(e_up[EXP_WIDTH-1:0] - lz), norm[3*FRAC_WIDTH-1 -: FRAC_WIDTH]};
endfunction

// Magic-number guess and one Newton step
function automatic fp_t inv_sqrt_float(input fp_t x);
	fp_t y;
	fp_t half_x;
	fp_t t;
	y = INV_SQRT_MAGIC - (x >> 1);
	half_x = {x[FP_WIDTH-1], x[FP_WIDTH-2 -: EXP_WIDTH] - 1'b1, x[FRAC_WIDTH-1:0]};
	t = mul_float(half_x, mul_float(y, y));
	t = add_float({~t[FP_WIDTH-1], t[FP_WIDTH-2:0]}, THREE_HALVES);
	return mul_float(y, t);
endfunction

// Scale by 2^frac_bits, truncate, saturate at the largest positive value
function automatic int_t float_to_fixed(input fp_t f, input int frac_bits);
	int se;
	logic [FRAC_WIDTH+INT_WIDTH-1:0] word;
	se = f[FP_WIDTH-2 -: EXP_WIDTH] + frac_bits;
	if (se < EXP_BIAS) begin
		return '0;
	end else if (se > EXP_BIAS + INT_WIDTH - 2) begin
		return {1'b0, {(INT_WIDTH-1){1'b1}}};
	end
	word = {1'b1, f[FRAC_WIDTH-1:0]};
	word = word << (se - EXP_BIAS);
	return word[FRAC_WIDTH+INT_WIDTH-1 -: INT_WIDTH];
endfunction

`endif

/* dv/inv_sqrt_unit_tb.sv */
`timescale 1ns/10ps
`default_nettype none

module inv_sqrt_unit_tb import fp_pkg::*; ();

	localparam int OUT_FRAC_BITS = 14;
	localparam int NUM_ITEMS = 500;
	// Edges from driving in_valid to out_valid through all three stages
	localparam int PIPE_LATENCY = 7;
	localparam int TIMEOUT_CYCLES = NUM_ITEMS * 20 + 100;

	logic clk;
	logic reset;
	logic in_valid;
	int_t in_value;
	logic out_valid;
	fp_t  out_fp;
	int_t out_fixed;

	integer seed;
	int cycle = 0;
	int checked = 0;
	// One scoreboard entry per accepted input
	int_t pending_value[$];
	int   pending_cycle[$];

	`include "fp_model.svh"

	inv_sqrt_unit #(
		.OUT_FRAC_BITS (OUT_FRAC_BITS)
	) dut (
		.clk       (clk),
		.reset     (reset),
		.in_valid  (in_valid),
		.in_value  (in_value),
		.out_valid (out_valid),
		.out_fp    (out_fp),
		.out_fixed (out_fixed)
	);

	// ====================================================================
	// Clock, cycle count, watchdog
	// ====================================================================
	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	always @(posedge clk) begin
		cycle <= cycle + 1;
	end

	initial begin
		repeat (TIMEOUT_CYCLES) @(posedge clk);
		report_failure("Timeout, results still outstanding after the cycle budget ran out");
	end

	// ====================================================================
	// Reporting and compare tasks
	// ====================================================================
	task automatic report_failure(input string what);
		$display("%s", what);
		$display("Regression failed");
		$fatal(1);
	endtask

	task automatic check_fp(input string name, input fp_t expected, input fp_t actual);
		if (actual !== expected) begin
			report_failure($sformatf("Fail %s float: expected %h, actual %h",
				name, expected, actual));
		end
	endtask

	// Bit-exact readout, then distance from the real 1/sqrt
	task automatic check_fixed(input string name, input int_t expected, input int_t actual,
		input int_t value);
		real ideal;
		real err;
		if (actual !== expected) begin
			report_failure($sformatf("Fail %s fixed: expected %0d, actual %0d",
				name, expected, actual));
		end
		ideal = (2.0 ** OUT_FRAC_BITS) / $sqrt($itor(value));
		err = $itor(actual) - ideal;
		if (err < 0.0) begin
			err = -err;
		end
		if (err > ideal * 0.01 + 1.0) begin
			report_failure($sformatf("Fail %s accuracy: expected %.2f, actual %0d",
				name, ideal, actual));
		end
	endtask

	task automatic check_latency(input string name, input int expected, input int actual);
		if (actual != expected) begin
			report_failure($sformatf("Fail %s latency: expected %0d, actual %0d",
				name, expected, actual));
		end
	endtask

	// Small values, powers of two, or anything nonzero
	function automatic int_t random_operand();
		int kind;
		int_t v;
		kind = {$random(seed)} % 4;
		if (kind == 0) begin
			v = 1 + {$random(seed)} % 16;
		end else if (kind == 1) begin
			v = 1 << ({$random(seed)} % INT_WIDTH);
		end else begin
			v = $random(seed);
		end
		// Zero lies outside the supported range
		if (v == '0) begin
			v = 1;
		end
		return v;
	endfunction

	// ====================================================================
	// Stimulus
	// ====================================================================
	initial begin : stimulus
		int_t value;
		int pick;
		int sent;
		seed = 32'hd9b45e29;
		sent = 0;
		reset = 1'b1;
		in_valid = 1'b0;
		in_value = '0;
		repeat (2) @(posedge clk);
		reset <= 1'b0;
		// out_valid must stay low through this idle stretch
		repeat (10) @(posedge clk);
		while (sent < NUM_ITEMS) begin
			@(posedge clk);
			pick = {$random(seed)} % 100;
			if (pick < 70) begin
				value = random_operand();
				in_valid <= 1'b1;
				in_value <= value;
				pending_value.push_back(value);
				// Edge count once this edge has passed
				pending_cycle.push_back(cycle + 1);
				sent++;
			end else begin
				in_valid <= 1'b0;
			end
		end
		@(posedge clk);
		in_valid <= 1'b0;
		while (pending_value.size() != 0) begin
			@(posedge clk);
		end
		// Room for any stray strobe to show up
		repeat (20) @(posedge clk);
		$display("Regression passed");
		$finish;
	end

	// ====================================================================
	// Scoreboard sampled mid-cycle
	// ====================================================================
	always @(negedge clk) begin : scoreboard
		int_t value;
		int start;
		fp_t want_fp;
		string name;
		if (!reset) begin
			if (out_valid === 1'b1) begin
				if (pending_value.size() == 0) begin
					report_failure("out_valid pulsed with no input outstanding");
				end else begin
					value = pending_value.pop_front();
					start = pending_cycle.pop_front();
					name = $sformatf("item %0d value %0d", checked, value);
					want_fp = inv_sqrt_float(int_to_float(value));
					check_latency(name, PIPE_LATENCY, cycle - start);
					check_fp(name, want_fp, out_fp);
					check_fixed(name, float_to_fixed(want_fp, OUT_FRAC_BITS), out_fixed, value);
					checked++;
				end
			end else if (out_valid !== 1'b0) begin
				report_failure("out_valid is unknown after reset");
			end
		end
	end

endmodule

`default_nettype wire

/* filelist.f */
+incdir+dv
hw/fp_pkg.sv
hw/fp_mul.sv
hw/fp_add.sv
hw/fp_inv_sqrt.sv
hw/int_to_fp.sv
hw/fp_to_fixed.sv
hw/inv_sqrt_unit.sv
dv/inv_sqrt_unit_tb.sv

/* hw/fp_add.sv */
`timescale 1ns/10ps
`default_nettype none

module fp_add import fp_pkg::*; (
	input  logic clk,
	input  fp_t  a,
	input  fp_t  b,
	output fp_t  sum
);

	// Guard bit, significand, then room for the shifted-out bits
	localparam int ALIGN_WIDTH = 2 * FRAC_WIDTH + 1;
	localparam int NORM_WIDTH = ALIGN_WIDTH + FRAC_WIDTH - 1;
	localparam int FLUSH_LIMIT = ALIGN_WIDTH - 2;
	localparam int SHIFT_WIDTH = $clog2(ALIGN_WIDTH + 1);

	logic                   a_sign;
	logic                   b_sign;
	logic [EXP_WIDTH-1:0]   a_exp;
	logic [EXP_WIDTH-1:0]   b_exp;
	logic [FRAC_WIDTH-1:0]  a_sig;
	logic [FRAC_WIDTH-1:0]  b_sig;
	logic                   a_larger;
	logic [EXP_WIDTH-1:0]   diff_a;
	logic [EXP_WIDTH-1:0]   diff_b;
	logic [EXP_WIDTH-1:0]   larger_exp;
	logic [ALIGN_WIDTH-1:0] a_aligned;
	logic [ALIGN_WIDTH-1:0] b_aligned;
	logic [ALIGN_WIDTH-1:0] raw_sum;

	// Stage one registers
	logic [ALIGN_WIDTH-1:0] s1_sum;
	logic [EXP_WIDTH-1:0]   s1_exp;
	logic                   s1_a_zero;
	logic                   s1_b_zero;
	fp_t                    s1_a;
	fp_t                    s1_b;
	logic                   s1_sign;

	logic [SHIFT_WIDTH-1:0] norm_shift;
	logic [NORM_WIDTH-1:0]  norm_word;
	logic [FRAC_WIDTH-1:0]  sum_frac;
	logic [EXP_WIDTH:0]     exp_up;
	logic [EXP_WIDTH-1:0]   sum_exp;
	logic                   underflow;

	// ====================================================================
	// Stage one, align and add
	// ====================================================================
	assign a_sign = a[FP_WIDTH-1];
	assign b_sign = b[FP_WIDTH-1];
	assign a_exp = a[FP_WIDTH-2 -: EXP_WIDTH];
	assign b_exp = b[FP_WIDTH-2 -: EXP_WIDTH];
	assign a_sig = {1'b1, a[FRAC_WIDTH-1:1]};
	assign b_sig = {1'b1, b[FRAC_WIDTH-1:1]};

	// Magnitude compare on exponent then significand
	assign a_larger = (a_exp > b_exp) || ((a_exp == b_exp) && (a_sig > b_sig));
	assign diff_a = b_exp - a_exp;
	assign diff_b = a_exp - b_exp;
	assign larger_exp = (b_exp > a_exp) ? b_exp : a_exp;

	// Smaller operand slides right, flushed when fully shifted out
	assign a_aligned = a_larger ? {1'b0, a_sig, {FRAC_WIDTH{1'b0}}} :
		(diff_a > FLUSH_LIMIT) ? '0 : ({1'b0, a_sig, {FRAC_WIDTH{1'b0}}} >> diff_a);
	assign b_aligned = !a_larger ? {1'b0, b_sig, {FRAC_WIDTH{1'b0}}} :
		(diff_b > FLUSH_LIMIT) ? '0 : ({1'b0, b_sig, {FRAC_WIDTH{1'b0}}} >> diff_b);

	// Opposite signs subtract smaller from larger
	assign raw_sum = ((a_sign ^ b_sign) && a_larger) ? (a_aligned - b_aligned) :
		((a_sign ^ b_sign) && !a_larger) ? (b_aligned - a_aligned) :
		(a_aligned + b_aligned);

	always_ff @(posedge clk) begin
		s1_sum <= raw_sum;
		s1_exp <= larger_exp;
		s1_a_zero <= (a_exp == '0);
		s1_b_zero <= (b_exp == '0);
		s1_a <= a;
		s1_b <= b;
		s1_sign <= a_larger ? a_sign : b_sign;
	end

	// ====================================================================
	// Stage two, normalize
	// ====================================================================
	// Leading zero count, ALIGN_WIDTH when the sum is zero
	always_comb begin
		norm_shift = SHIFT_WIDTH'(ALIGN_WIDTH);
		for (int i = 0; i < ALIGN_WIDTH; i++) begin
			if (s1_sum[i]) begin
				norm_shift = SHIFT_WIDTH'(ALIGN_WIDTH - 1 - i);
			end
		end
	end

	// Extra place of shift drops the hidden one
	assign norm_word = {s1_sum, {(FRAC_WIDTH-1){1'b0}}} << (norm_shift + 1'b1);
	assign sum_frac = norm_word[NORM_WIDTH-1 -: FRAC_WIDTH];

	// Guard bit position counts as one above the larger exponent
	assign exp_up = {1'b0, s1_exp} + 1'b1;
	assign sum_exp = exp_up[EXP_WIDTH-1:0] - EXP_WIDTH'(norm_shift);
	assign underflow = (exp_up <= (EXP_WIDTH+1)'(norm_shift));

	always_ff @(posedge clk) begin
		if (s1_a_zero && s1_b_zero) begin
			sum <= '0;
		end else if (s1_a_zero) begin
			sum <= s1_b;
		end else if (s1_b_zero) begin
			sum <= s1_a;
		end else if (underflow || (s1_sum == '0)) begin
			sum <= '0;
		end else begin
			sum <= {s1_sign, sum_exp, sum_frac};
		end
	end

endmodule

`default_nettype wire

/* hw/fp_inv_sqrt.sv */
`timescale 1ns/10ps
`default_nettype none

module fp_inv_sqrt import fp_pkg::*; (
	input  logic clk,
	input  logic reset,
	input  logic conv_valid,
	input  fp_t  conv_fp,
	output logic isq_valid,
	output fp_t  isq_fp
);

	// Two multiply stages, the adder, then the last operand register
	localparam int Y_DEPTH = ADD_LATENCY + 3;

	logic                  x_sign;
	logic [EXP_WIDTH-1:0]  x_exp;
	logic [FRAC_WIDTH-1:0] x_frac;
	fp_t                   y_guess;
	fp_t                   half_x;
	fp_t                   y_sq;
	fp_t                   half_x_q;
	fp_t                   y_sq_q;
	fp_t                   xy2;
	fp_t                   xy2_q;
	fp_t                   neg_xy2;
	fp_t                   newton_term;
	fp_t                   newton_term_q;
	fp_t                   y_pipe [Y_DEPTH];
	logic [INV_SQRT_LATENCY-1:0] valid_pipe;

	assign x_sign = conv_fp[FP_WIDTH-1];
	assign x_exp = conv_fp[FP_WIDTH-2 -: EXP_WIDTH];
	assign x_frac = conv_fp[FRAC_WIDTH-1:0];

	// ====================================================================
	// Stage 1, initial guess and y squared
	// ====================================================================
	// Whole-word shift halves the exponent, magic corrects the bias
	assign y_guess = INV_SQRT_MAGIC - (conv_fp >> 1);
	// x/2 by exponent decrement
	assign half_x = {x_sign, x_exp - 1'b1, x_frac};

	fp_mul u_mul_ysq (.a(y_guess), .b(y_guess), .prod(y_sq));

	always_ff @(posedge clk) begin
		half_x_q <= half_x;
		y_sq_q <= y_sq;
	end

	// Stage 2, x/2 * y^2
	fp_mul u_mul_xy2 (.a(half_x_q), .b(y_sq_q), .prod(xy2));

	always_ff @(posedge clk) begin
		xy2_q <= xy2;
	end

	// Stages 3 and 4, 1.5 - x/2 * y^2 through the adder
	assign neg_xy2 = {~xy2_q[FP_WIDTH-1], xy2_q[FP_WIDTH-2:0]};

	fp_add u_add_newton (.clk(clk), .a(neg_xy2), .b(THREE_HALVES), .sum(newton_term));

	always_ff @(posedge clk) begin
		newton_term_q <= newton_term;
	end

	// Guess rides along so each item meets its own Newton term
	always_ff @(posedge clk) begin
		y_pipe[0] <= y_guess;
		for (int i = 1; i < Y_DEPTH; i++) begin
			y_pipe[i] <= y_pipe[i-1];
		end
	end

	// Stage 5, y * (1.5 - x/2 * y^2)
	fp_mul u_mul_out (.a(y_pipe[Y_DEPTH-1]), .b(newton_term_q), .prod(isq_fp));

	// Valid strobe tracks the data, one bit per stage
	always_ff @(posedge clk) begin
		if (reset) begin
			valid_pipe <= '0;
		end else begin
			valid_pipe <= {valid_pipe[INV_SQRT_LATENCY-2:0], conv_valid};
		end
	end

	assign isq_valid = valid_pipe[INV_SQRT_LATENCY-1];

endmodule

`default_nettype wire

/* hw/fp_mul.sv */
`timescale 1ns/10ps
`default_nettype none

module fp_mul import fp_pkg::*; (
	input  fp_t a,
	input  fp_t b,
	output fp_t prod
);

	localparam int PROD_WIDTH = 2 * FRAC_WIDTH;
	localparam logic [EXP_WIDTH:0] BIAS_W = (EXP_WIDTH+1)'(EXP_BIAS);
	localparam logic [EXP_WIDTH:0] BIAS_M1 = (EXP_WIDTH+1)'(EXP_BIAS - 1);

	logic                  a_sign;
	logic                  b_sign;
	logic [EXP_WIDTH-1:0]  a_exp;
	logic [EXP_WIDTH-1:0]  b_exp;
	// Hidden one plus top fraction bits, fraction LSB dropped
	logic [FRAC_WIDTH-1:0] a_sig;
	logic [FRAC_WIDTH-1:0] b_sig;
	logic [PROD_WIDTH-1:0] sig_prod;
	logic [EXP_WIDTH:0]    exp_sum;
	logic [EXP_WIDTH:0]    exp_adj;
	logic [FRAC_WIDTH-1:0] prod_frac;
	logic                  underflow;

	// Field split
	assign a_sign = a[FP_WIDTH-1];
	assign b_sign = b[FP_WIDTH-1];
	assign a_exp = a[FP_WIDTH-2 -: EXP_WIDTH];
	assign b_exp = b[FP_WIDTH-2 -: EXP_WIDTH];
	assign a_sig = {1'b1, a[FRAC_WIDTH-1:1]};
	assign b_sig = {1'b1, b[FRAC_WIDTH-1:1]};

	// Significand product lies in [1,4)
	assign sig_prod = a_sig * b_sig;
	assign exp_sum = {1'b0, a_exp} + {1'b0, b_exp};

	// Top bit set means one extra power of two
	assign exp_adj = sig_prod[PROD_WIDTH-1] ? (exp_sum - BIAS_M1) : (exp_sum - BIAS_W);
	assign prod_frac = sig_prod[PROD_WIDTH-1] ? sig_prod[PROD_WIDTH-2 -: FRAC_WIDTH] :
		sig_prod[PROD_WIDTH-3 -: FRAC_WIDTH];

	// Sum below 128 leaves no room for a biased exponent
	assign underflow = (exp_sum <= BIAS_W);

	// Zero exponent on either side means a zero operand
	assign prod = (underflow || (a_exp == '0) || (b_exp == '0)) ? '0 :
		{a_sign ^ b_sign, exp_adj[EXP_WIDTH-1:0], prod_frac};

endmodule

`default_nettype wire

/* hw/fp_pkg.sv */
`default_nettype none

package fp_pkg;

	// ====================================================================
	// Custom 27-bit float format
	// ====================================================================
	// Sign on top, then exponent, then fraction
	// Value is (-1)^s * 2^(e - bias) * 1.f
	parameter int FP_WIDTH = 27;
	parameter int EXP_WIDTH = 8;
	parameter int FRAC_WIDTH = 18;
	// Exponent code for 2^0
	parameter int EXP_BIAS = 127;

	// Integer input and fixed point output width
	parameter int INT_WIDTH = 16;

	typedef logic [FP_WIDTH-1:0] fp_t;
	typedef logic [INT_WIDTH-1:0] int_t;

	// ====================================================================
	// Fast inverse square root constants
	// ====================================================================
	// Initial guess magic number, re-derived for this format
	parameter fp_t INV_SQRT_MAGIC = 27'd49920718;
	// 1.5 encoded as exponent 127 with fraction MSB set
	parameter fp_t THREE_HALVES = 27'd33423360;

	// Pipeline depths in clock cycles
	parameter int ADD_LATENCY = 2;
	parameter int INV_SQRT_LATENCY = 5;

endpackage

`default_nettype wire

/* hw/fp_to_fixed.sv */
`timescale 1ns/10ps
`default_nettype none

module fp_to_fixed import fp_pkg::*; #(
	parameter int OUT_FRAC_BITS = 14
) (
	input  logic clk,
	input  logic reset,
	input  logic isq_valid,
	input  fp_t  isq_fp,
	output logic out_valid,
	output fp_t  out_fp,
	output int_t out_fixed
);

	localparam int BUF_WIDTH = INT_WIDTH + FRAC_WIDTH;
	localparam logic [EXP_WIDTH:0] BIAS_W = (EXP_WIDTH+1)'(EXP_BIAS);
	// Largest exponent whose integer part still fits below the sign bit
	localparam logic [EXP_WIDTH:0] SAT_EXP = (EXP_WIDTH+1)'(EXP_BIAS + INT_WIDTH - 2);
	localparam int_t SAT_VALUE = {1'b0, {(INT_WIDTH-1){1'b1}}};

	logic [EXP_WIDTH:0]   scaled_exp;
	logic [EXP_WIDTH:0]   shift_amt;
	logic [BUF_WIDTH-1:0] shift_buf;
	int_t                 fixed_value;

	// Multiply by 2^OUT_FRAC_BITS through the exponent
	assign scaled_exp = {1'b0, isq_fp[FP_WIDTH-2 -: EXP_WIDTH]} +
		(EXP_WIDTH+1)'(OUT_FRAC_BITS);
	assign shift_amt = scaled_exp - BIAS_W;

	// 1.f with the hidden one just above the fraction, moved into the integer field
	assign shift_buf = {{(INT_WIDTH-1){1'b0}}, 1'b1, isq_fp[FRAC_WIDTH-1:0]} << shift_amt;

	always_comb begin
		if (scaled_exp < BIAS_W) begin
			// Below one LSB, truncates to zero
			fixed_value = '0;
		end else if (scaled_exp > SAT_EXP) begin
			fixed_value = SAT_VALUE;
		end else begin
			fixed_value = shift_buf[BUF_WIDTH-1 -: INT_WIDTH];
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			out_valid <= 1'b0;
		end else begin
			out_valid <= isq_valid;
		end
	end

	// Float passes through unscaled next to its fixed point value
	always_ff @(posedge clk) begin
		out_fixed <= fixed_value;
		out_fp <= isq_fp;
	end

endmodule

`default_nettype wire

/* hw/int_to_fp.sv */
`timescale 1ns/10ps
`default_nettype none

module int_to_fp import fp_pkg::*; (
	input  logic clk,
	input  logic reset,
	input  logic in_valid,
	input  int_t in_value,
	output logic conv_valid,
	output fp_t  conv_fp
);

	localparam int POS_WIDTH = $clog2(INT_WIDTH);
	localparam int BUF_WIDTH = INT_WIDTH + FRAC_WIDTH;

	logic [POS_WIDTH-1:0] lead_pos;
	logic [BUF_WIDTH-1:0] frac_buf;
	logic [EXP_WIDTH-1:0] conv_exp;

	// Position of the leading one, highest set bit wins
	always_comb begin
		lead_pos = '0;
		for (int i = 0; i < INT_WIDTH; i++) begin
			if (in_value[i]) begin
				lead_pos = POS_WIDTH'(i);
			end
		end
	end

	// Leading one lands just above the fraction field
	// Bits below it end up left-aligned
	assign frac_buf = {in_value, {FRAC_WIDTH{1'b0}}} >> lead_pos;

	// 2^lead_pos
	assign conv_exp = EXP_WIDTH'(EXP_BIAS) + EXP_WIDTH'(lead_pos);

	always_ff @(posedge clk) begin
		if (reset) begin
			conv_valid <= 1'b0;
		end else begin
			conv_valid <= in_valid;
		end
	end

	// Unsigned input, sign bit always clear
	always_ff @(posedge clk) begin
		if (in_valid) begin
			conv_fp <= (in_value == '0) ? '0 : {1'b0, conv_exp, frac_buf[FRAC_WIDTH-1:0]};
		end
	end

endmodule

`default_nettype wire

/* hw/inv_sqrt_unit.sv */
`timescale 1ns/10ps
`default_nettype none

module inv_sqrt_unit import fp_pkg::*; #(
	parameter int OUT_FRAC_BITS = 14
) (
	input  logic clk,
	input  logic reset,
	input  logic in_valid,
	input  int_t in_value,
	output logic out_valid,
	output fp_t  out_fp,
	output int_t out_fixed
);

	// ====================================================================
	// Convert, 1/sqrt, fixed point readout
	// ====================================================================
	logic conv_valid;
	fp_t  conv_fp;
	logic isq_valid;
	fp_t  isq_fp;

	// 1 cycle
	int_to_fp u_int_to_fp (
		.clk        (clk),
		.reset      (reset),
		.in_valid   (in_valid),
		.in_value   (in_value),
		.conv_valid (conv_valid),
		.conv_fp    (conv_fp)
	);

	// INV_SQRT_LATENCY cycles
	fp_inv_sqrt u_fp_inv_sqrt (
		.clk        (clk),
		.reset      (reset),
		.conv_valid (conv_valid),
		.conv_fp    (conv_fp),
		.isq_valid  (isq_valid),
		.isq_fp     (isq_fp)
	);

	// 1 cycle, output scale set here
	fp_to_fixed #(
		.OUT_FRAC_BITS (OUT_FRAC_BITS)
	) u_fp_to_fixed (
		.clk       (clk),
		.reset     (reset),
		.isq_valid (isq_valid),
		.isq_fp    (isq_fp),
		.out_valid (out_valid),
		.out_fp    (out_fp),
		.out_fixed (out_fixed)
	);

endmodule

`default_nettype wire
